/* coinLockout.sv */
`timescale 1ns/1ps

module coinLockout (
	input logic CLK_68KCLK,
	input logic rst,
	ioRegIf.block regBus,
	output logic counter1,
	output logic counter2,
	output logic lockout1,
	output logic lockout2
);

	logic cntHit;
	logic setVal;

	// Counter group lives at A6-A5 = 3 in BITW0
	assign cntHit = regBus.bitw0Strobe && (regBus.regAddr[6:5] == neoIoPkg::SUB_CNT_GROUP);
	// A4 high sets, low clears
	assign setVal = regBus.regAddr[4];

	always_ff @(posedge CLK_68KCLK) begin
		if (rst) begin
			counter1 <= 1'b0;
			counter2 <= 1'b0;
			lockout1 <= 1'b0;
			lockout2 <= 1'b0;
		end else if (cntHit) begin
			// Target from A2-A1, data bus is not looked at
			case (regBus.regAddr[2:1])
				2'd0: counter1 <= setVal;
				2'd1: counter2 <= setVal;
				2'd2: lockout1 <= setVal;
				default: lockout2 <= setVal;
			endcase
		end
	end

endmodule

/* ioRegIf.sv */
`timescale 1ns/1ps

interface ioRegIf;

	// One-cycle write strobes per zone
	logic bitw0Strobe;
	logic bitw1Strobe;
	// Address bits 6-1, valid with the strobe
	logic [6:1] regAddr;
	logic [neoIoPkg::DATA_W-1:0] regData;

	// Decoder side
	modport decoder (
		output bitw0Strobe,
		output bitw1Strobe,
		output regAddr,
		output regData
	);

	// Write block side
	modport block (
		input bitw0Strobe,
		input bitw1Strobe,
		input regAddr,
		input regData
	);

endinterface

/* ioZoneDecode.sv */
`timescale 1ns/1ps

module ioZoneDecode (
	input logic CLK_68KCLK,
	input logic rst,
	input logic busStrobe,
	input logic busWrite,
	input logic [neoIoPkg::ADDR_W-1:0] busAddr,
	input logic [neoIoPkg::DATA_W-1:0] busWdata,
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic [7:0] dipSw,
	input logic testBtn,
	output logic [neoIoPkg::DATA_W-1:0] rdData,
	output logic rdValid,
	ioRegIf.decoder regBus
);

	logic p1Hit;
	logic dipHit;
	logic p2Hit;
	logic statusBHit;
	logic bitw0Hit;
	logic bitw1Hit;
	logic rdStrobe;
	logic [neoIoPkg::DATA_W-1:0] rdSel;

	// Zone matches, all from one masked compare each
	assign p1Hit = (busAddr & neoIoPkg::ZONE_MASK) == neoIoPkg::P1CNT_ADDR;
	assign dipHit = (busAddr & neoIoPkg::ZONE_MASK) == neoIoPkg::DIPRD0_ADDR;
	assign statusBHit = (busAddr & neoIoPkg::ZONE_MASK) == neoIoPkg::STATUSB_ADDR;
	assign bitw0Hit = (busAddr & neoIoPkg::ZONE_MASK) == neoIoPkg::BITW0_ADDR;
	assign bitw1Hit = (busAddr & neoIoPkg::ZONE_MASK) == neoIoPkg::BITW1_ADDR;
	// P2 uses a looser mask
	assign p2Hit = (busAddr & neoIoPkg::P2CNT_MASK) == neoIoPkg::P2CNT_ADDR;

	assign rdStrobe = busStrobe & ~busWrite;

	// Write strobes go out in the sampling cycle
	assign regBus.bitw0Strobe = busStrobe & busWrite & bitw0Hit;
	assign regBus.bitw1Strobe = busStrobe & busWrite & bitw1Hit;
	assign regBus.regAddr = busAddr[6:1];
	assign regBus.regData = busWdata;

	// Read mux
	always_comb begin
		if (p1Hit) begin
			rdSel = p1In[7:0];
		end else if (dipHit) begin
			// Test button byte has only bit 7 live
			if (busAddr[neoIoPkg::DIP_TEST_BIT])
				rdSel = {testBtn, 7'h7F};
			else
				rdSel = dipSw;
		end else if (p2Hit) begin
			rdSel = p2In[7:0];
		end else if (statusBHit) begin
			// Upper joypad bits, unused bits float high
			rdSel = {4'hF, p2In[9:8], p1In[9:8]};
		end else begin
			rdSel = neoIoPkg::UNMAPPED_DATA;
		end
	end

	// Read data is only loaded on a read
	always_ff @(posedge CLK_68KCLK) begin
		if (rdStrobe)
			rdData <= rdSel;
	end

	always_ff @(posedge CLK_68KCLK) begin
		if (rst)
			rdValid <= 1'b0;
		else
			rdValid <= rdStrobe;
	end

endmodule

/* neoIo.f */
neoIoPkg.sv
ioRegIf.sv
ioZoneDecode.sv
outputLatches.sv
coinLockout.sv
systemLatch.sv
neoIoTop.sv
tbClock.sv
neoIoTb.sv

/* neoIoPkg.sv */
package neoIoPkg;

	// Bus widths
	localparam int ADDR_W = 24;
	localparam int DATA_W = 8;

	// Zone select keeps A21-A17 and the byte lane bit A0
	localparam logic [ADDR_W-1:0] ZONE_MASK = 24'h3E0001;

	// Read zones
	localparam logic [ADDR_W-1:0] P1CNT_ADDR = 24'h300000;
	localparam logic [ADDR_W-1:0] DIPRD0_ADDR = 24'h300001;
	localparam logic [ADDR_W-1:0] P2CNT_ADDR = 24'h340000;
	localparam logic [ADDR_W-1:0] STATUSB_ADDR = 24'h380000;

	// Write zones
	localparam logic [ADDR_W-1:0] BITW0_ADDR = 24'h380001;
	localparam logic [ADDR_W-1:0] BITW1_ADDR = 24'h3A0001;

	// P2CNT ignores A17, so it is mirrored at 0x360000
	localparam logic [ADDR_W-1:0] P2CNT_MASK = 24'h3C0001;

	// A7 picks the test button byte inside DIPRD0
	localparam int DIP_TEST_BIT = 7;

	// Open bus value for anything not mapped here
	localparam logic [DATA_W-1:0] UNMAPPED_DATA = 8'hFF;

	// BITW0 sub-addresses on A6-A4
	localparam logic [2:0] SUB_POUTPUT = 3'd0;
	localparam logic [2:0] SUB_SLOT = 3'd2;
	localparam logic [2:0] SUB_LEDLATCH = 3'd3;
	localparam logic [2:0] SUB_LEDDATA = 3'd4;
	// Counter group when A6-A5 are both set
	localparam logic [1:0] SUB_CNT_GROUP = 2'd3;

	// System latch bit indices, selected by A3-A1
	localparam logic [2:0] LATCH_SHADOW = 3'd0;
	localparam logic [2:0] LATCH_NVEC = 3'd1;
	localparam logic [2:0] LATCH_NCARDWEN = 3'd2;
	localparam logic [2:0] LATCH_CARDWENB = 3'd3;
	localparam logic [2:0] LATCH_NREGEN = 3'd4;
	localparam logic [2:0] LATCH_NSYSTEM = 3'd5;
	localparam logic [2:0] LATCH_SRAMWEN = 3'd6;
	localparam logic [2:0] LATCH_PALBNK = 3'd7;

	// Cartridge slots and serial LED/EL data widths
	localparam int SLOT_COUNT = 6;
	localparam int LED_W = 8;
	localparam int EL_W = 3;

endpackage

/* neoIoTb.sv */
`timescale 1ns/1ps

module neoIoTb;

	// Ceiling well above the few hundred cycles that the tests need
	localparam int CYCLE_LIMIT = 2000;

	logic clk;
	logic rst;
	logic busStrobe;
	logic busWrite;
	logic [23:0] busAddr;
	logic [7:0] busWdata;
	logic [7:0] rdData;
	logic rdValid;
	logic [9:0] p1In;
	logic [9:0] p2In;
	logic [7:0] dipSw;
	logic testBtn;
	logic [2:0] p1Out;
	logic [2:0] p2Out;
	logic [5:0] slotSel;
	logic [8:0] ledOut1;
	logic [8:0] ledOut2;
	logic [3:0] elOut;
	logic counter1;
	logic counter2;
	logic lockout1;
	logic lockout2;
	logic shadow;
	logic palBank;
	logic nSystem;
	logic sramWriteLock;
	logic cardWriteEnable;
	logic cardRegEnable;
	logic [1:0] vecAddrHi;
	int cycleCount = 0;

	tbClock i_tbClock (.clk(clk));

	neoIoTop i_neoIoTop (
		.CLK_68KCLK(clk),
		.rst(rst),
		.busStrobe(busStrobe),
		.busWrite(busWrite),
		.busAddr(busAddr),
		.busWdata(busWdata),
		.rdData(rdData),
		.rdValid(rdValid),
		.p1In(p1In),
		.p2In(p2In),
		.dipSw(dipSw),
		.testBtn(testBtn),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.slotSel(slotSel),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2),
		.elOut(elOut),
		.counter1(counter1),
		.counter2(counter2),
		.lockout1(lockout1),
		.lockout2(lockout2),
		.shadow(shadow),
		.palBank(palBank),
		.nSystem(nSystem),
		.sramWriteLock(sramWriteLock),
		.cardWriteEnable(cardWriteEnable),
		.cardRegEnable(cardRegEnable),
		.vecAddrHi(vecAddrHi)
	);

	// Run length guard
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$fatal(1, "simulation ran too long");
		end
	end

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// One bus write that returns on the falling edge after the sampling edge
	task automatic writeReg(input logic [23:0] addr, input logic [7:0] data);
		@(negedge clk);
		busStrobe = 1'b1;
		busWrite = 1'b1;
		busAddr = addr;
		busWdata = data;
		@(negedge clk);
		busStrobe = 1'b0;
		busWrite = 1'b0;
		busAddr = '0;
		busWdata = '0;
	endtask

	// Single read with data due for the one cycle after the strobe
	task automatic readCheck(input logic [23:0] addr, input logic [7:0] exp, input string what);
		@(negedge clk);
		busStrobe = 1'b1;
		busWrite = 1'b0;
		busAddr = addr;
		@(negedge clk);
		busStrobe = 1'b0;
		busAddr = '0;
		checkValue(32'(rdValid), 1, {what, " rdValid"});
		checkValue(32'(rdData), 32'(exp), what);
		@(negedge clk);
		checkValue(32'(rdValid), 0, {what, " rdValid second cycle"});
	endtask

	// Flag outputs as the latch bits should give them
	task automatic checkFlags(input logic [7:0] lat);
		checkValue(32'(shadow), 32'(lat[neoIoPkg::LATCH_SHADOW]), "shadow");
		checkValue(32'(palBank), 32'(lat[neoIoPkg::LATCH_PALBNK]), "palBank");
		checkValue(32'(nSystem), 32'(lat[neoIoPkg::LATCH_NSYSTEM]), "nSystem");
		checkValue(32'(sramWriteLock), 32'(lat[neoIoPkg::LATCH_SRAMWEN]), "sramWriteLock");
		checkValue(32'(cardWriteEnable),
			32'(!lat[neoIoPkg::LATCH_NCARDWEN] && lat[neoIoPkg::LATCH_CARDWENB]),
			"cardWriteEnable");
		checkValue(32'(cardRegEnable), 32'(!lat[neoIoPkg::LATCH_NREGEN]), "cardRegEnable");
	endtask

	// Address goes out on one falling edge and the result is looked at on the next
	task automatic vecCheck(input logic [23:0] addr, input logic [1:0] exp);
		@(negedge clk);
		busAddr = addr;
		@(negedge clk);
		checkValue(32'(vecAddrHi), 32'(exp), "vecAddrHi");
	endtask

	task automatic resetTest();
		@(negedge clk);
		checkValue(32'({p2Out, p1Out}), 0, "port outputs after reset");
		checkValue(32'(slotSel), 32'h3F, "slotSel after reset");
		checkValue(32'({ledOut2[8], ledOut1[8], elOut[3]}), 0, "clocks after reset");
		checkValue(32'({lockout2, lockout1, counter2, counter1}), 0, "coin outputs after reset");
		checkFlags(8'h00);
		// Bus parked at 0 with NVEC low keeps the swap on
		checkValue(32'(vecAddrHi), 3, "vecAddrHi after reset");
		repeat (5) begin
			@(negedge clk);
			checkValue(32'(rdValid), 0, "rdValid while idle");
		end
	endtask

	task automatic inputReadTest();
		logic [7:0] statusB;
		repeat (4) begin
			@(negedge clk);
			p1In = 10'($urandom);
			p2In = 10'($urandom);
			dipSw = 8'($urandom);
			testBtn = 1'($urandom);
			// Joypad high bits packed low with ones above
			statusB = {4'hF, p2In[9:8], p1In[9:8]};
			readCheck(24'h300000, p1In[7:0], "P1CNT");
			readCheck(24'h360000, p2In[7:0], "P2CNT mirror");
			readCheck(24'h300001, dipSw, "DIPRD0");
			readCheck(24'h300081, {testBtn, 7'h7F}, "test button");
			readCheck(24'h380000, statusB, "STATUS_B");
			readCheck(24'h320001, 8'hFF, "unmapped");
			// Three reads with no gap between strobes
			@(negedge clk);
			busStrobe = 1'b1;
			busWrite = 1'b0;
			busAddr = 24'h300000;
			@(negedge clk);
			busAddr = 24'h380000;
			checkValue(32'(rdValid), 1, "burst rdValid 1");
			checkValue(32'(rdData), 32'(p1In[7:0]), "burst P1CNT");
			@(negedge clk);
			busAddr = 24'h300001;
			checkValue(32'(rdValid), 1, "burst rdValid 2");
			checkValue(32'(rdData), 32'(statusB), "burst STATUS_B");
			@(negedge clk);
			busStrobe = 1'b0;
			busAddr = '0;
			checkValue(32'(rdValid), 1, "burst rdValid 3");
			checkValue(32'(rdData), 32'(dipSw), "burst DIPRD0");
			@(negedge clk);
			checkValue(32'(rdValid), 0, "burst rdValid end");
		end
	endtask

	task automatic portWriteTest();
		logic [7:0] data;
		logic [5:0] expSlot;
		data = 8'($urandom);
		writeReg(24'h380001, data);
		checkValue(32'(p1Out), 32'(data[2:0]), "p1Out");
		checkValue(32'(p2Out), 32'(data[5:3]), "p2Out");
		// Codes 6 and 7 select no slot
		for (int v = 0; v < 8; v++) begin
			data = {5'($urandom), 3'(v)};
			expSlot = (v < 6) ? ~(6'd1 << v) : 6'h3F;
			writeReg(24'h380021, data);
			checkValue(32'(slotSel), 32'(expSlot), "slotSel");
		end
		data = 8'($urandom);
		writeReg(24'h380041, data);
		checkValue(32'({ledOut2[8], ledOut1[8], elOut[3]}), 0, "clocks after LEDDATA");
		// Pulse is high in the cycle after the latch write and low in the next one
		for (int b = 3; b < 6; b++) begin
			writeReg(24'h380031, 8'(1 << b));
			checkValue(32'({ledOut2[8], ledOut1[8], elOut[3]}), 32'(1 << (b - 3)), "clock pulse");
			checkValue(32'(ledOut1[7:0]), 32'(data), "ledOut1 data");
			checkValue(32'(ledOut2[7:0]), 32'(data), "ledOut2 data");
			checkValue(32'(elOut[2:0]), 32'(data[2:0]), "elOut data");
			@(negedge clk);
			checkValue(32'({ledOut2[8], ledOut1[8], elOut[3]}), 0, "clock pulse end");
		end
	endtask

	task automatic coinTest();
		logic [3:0] expCoin;
		logic [23:0] addr;
		expCoin = '0;
		// Group on A6-A5 with set or clear on A4 and the target on A2-A1
		for (int t = 0; t < 4; t++) begin
			for (int s = 1; s >= 0; s--) begin
				addr = {16'h3800, 3'b011, 1'(s), 1'b0, 2'(t), 1'b1};
				writeReg(addr, 8'($urandom));
				expCoin[t] = 1'(s);
				checkValue(32'({lockout2, lockout1, counter2, counter1}), 32'(expCoin),
					"coin outputs");
			end
		end
	endtask

	task automatic latchTest();
		logic [7:0] expLatch;
		logic [23:0] addr;
		expLatch = '0;
		// CARDWENB held high so that NCARDWEN shows on cardWriteEnable
		writeReg(24'h3A0017, 8'h00);
		expLatch[neoIoPkg::LATCH_CARDWENB] = 1'b1;
		checkFlags(expLatch);
		for (int i = 0; i < 8; i++) begin
			for (int v = 1; v >= 0; v--) begin
				writeReg({16'h3A00, 3'b000, 1'(v), 3'(i), 1'b1}, 8'($urandom));
				expLatch[i] = 1'(v);
				checkFlags(expLatch);
				// NVEC shows up only through the swap at address 0
				@(negedge clk);
				checkValue(32'(vecAddrHi), expLatch[1] ? 0 : 3, "vecAddrHi at 0");
			end
		end
		// Vector swap on
		vecCheck(24'h000010, 2'd3);
		vecCheck(24'hC00010, 2'd0);
		vecCheck(24'h000100, 2'd0);
		vecCheck(24'h400010, 2'd1);
		// With NVEC set every address passes through
		writeReg(24'h3A0013, 8'h00);
		vecCheck(24'h000010, 2'd0);
		vecCheck(24'hC00010, 2'd3);
		vecCheck(24'h800010, 2'd2);
		repeat (8) begin
			addr = 24'($urandom);
			vecCheck(addr, addr[23:22]);
		end
	endtask

	initial begin
		void'($urandom(32'h40bb));
		rst = 1'b1;
		busStrobe = 1'b0;
		busWrite = 1'b0;
		busAddr = '0;
		busWdata = '0;
		p1In = '0;
		p2In = '0;
		dipSw = '0;
		testBtn = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		resetTest();
		inputReadTest();
		portWriteTest();
		coinTest();
		latchTest();
		$display("Testbench passed");
		$finish;
	end

endmodule

/* neoIoTop.sv */
`timescale 1ns/1ps

module neoIoTop (
	input logic CLK_68KCLK,
	input logic rst,
	// CPU side byte bus
	input logic busStrobe,
	input logic busWrite,
	input logic [neoIoPkg::ADDR_W-1:0] busAddr,
	input logic [neoIoPkg::DATA_W-1:0] busWdata,
	output logic [neoIoPkg::DATA_W-1:0] rdData,
	output logic rdValid,
	// Cabinet inputs
	input logic [9:0] p1In,
	input logic [9:0] p2In,
	input logic [7:0] dipSw,
	input logic testBtn,
	// Port, slot and LED outputs
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [neoIoPkg::SLOT_COUNT-1:0] slotSel,
	output logic [neoIoPkg::LED_W:0] ledOut1,
	output logic [neoIoPkg::LED_W:0] ledOut2,
	output logic [neoIoPkg::EL_W:0] elOut,
	// Coin mechanics
	output logic counter1,
	output logic counter2,
	output logic lockout1,
	output logic lockout2,
	// System latch flags
	output logic shadow,
	output logic palBank,
	output logic nSystem,
	output logic sramWriteLock,
	output logic cardWriteEnable,
	output logic cardRegEnable,
	output logic [1:0] vecAddrHi
);

	ioRegIf regBus ();

	ioZoneDecode i_ioZoneDecode (
		.CLK_68KCLK(CLK_68KCLK),
		.rst(rst),
		.busStrobe(busStrobe),
		.busWrite(busWrite),
		.busAddr(busAddr),
		.busWdata(busWdata),
		.p1In(p1In),
		.p2In(p2In),
		.dipSw(dipSw),
		.testBtn(testBtn),
		.rdData(rdData),
		.rdValid(rdValid),
		.regBus(regBus.decoder)
	);

	outputLatches i_outputLatches (
		.CLK_68KCLK(CLK_68KCLK),
		.rst(rst),
		.regBus(regBus.block),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.slotSel(slotSel),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2),
		.elOut(elOut)
	);

	coinLockout i_coinLockout (
		.CLK_68KCLK(CLK_68KCLK),
		.rst(rst),
		.regBus(regBus.block),
		.counter1(counter1),
		.counter2(counter2),
		.lockout1(lockout1),
		.lockout2(lockout2)
	);

	// Vector swap looks at the raw bus address
	systemLatch i_systemLatch (
		.CLK_68KCLK(CLK_68KCLK),
		.rst(rst),
		.regBus(regBus.block),
		.busAddr(busAddr),
		.shadow(shadow),
		.palBank(palBank),
		.nSystem(nSystem),
		.sramWriteLock(sramWriteLock),
		.cardWriteEnable(cardWriteEnable),
		.cardRegEnable(cardRegEnable),
		.vecAddrHi(vecAddrHi)
	);

endmodule

/* outputLatches.sv */
`timescale 1ns/1ps

module outputLatches (
	input logic CLK_68KCLK,
	input logic rst,
	ioRegIf.block regBus,
	output logic [2:0] p1Out,
	output logic [2:0] p2Out,
	output logic [neoIoPkg::SLOT_COUNT-1:0] slotSel,
	output logic [neoIoPkg::LED_W:0] ledOut1,
	output logic [neoIoPkg::LED_W:0] ledOut2,
	output logic [neoIoPkg::EL_W:0] elOut
);

	logic [2:0] subAddr;
	logic latchWrite;
	logic [neoIoPkg::SLOT_COUNT-1:0] slotNext;
	logic [neoIoPkg::LED_W-1:0] ledData;
	logic elClk;
	logic led1Clk;
	logic led2Clk;

	// Register select is A6-A4 inside BITW0
	assign subAddr = regBus.regAddr[6:4];
	assign latchWrite = regBus.bitw0Strobe && (subAddr == neoIoPkg::SUB_LEDLATCH);

	// One-cold slot select, out of range codes leave every slot off
	always_comb begin
		for (int i = 0; i < neoIoPkg::SLOT_COUNT; i++)
			slotNext[i] = regBus.regData[2:0] != 3'(i);
	end

	always_ff @(posedge CLK_68KCLK) begin
		if (rst) begin
			p1Out <= '0;
			p2Out <= '0;
			slotSel <= '1;
		end else if (regBus.bitw0Strobe) begin
			case (subAddr)
				neoIoPkg::SUB_POUTPUT: begin
					p1Out <= regBus.regData[2:0];
					p2Out <= regBus.regData[5:3];
				end
				neoIoPkg::SUB_SLOT: slotSel <= slotNext;
				default: ;
			endcase
		end
	end

	// LED serial data
	always_ff @(posedge CLK_68KCLK) begin
		if (regBus.bitw0Strobe && (subAddr == neoIoPkg::SUB_LEDDATA))
			ledData <= regBus.regData;
	end

	// Clock pulses last exactly one cycle after the latch write
	always_ff @(posedge CLK_68KCLK) begin
		if (rst) begin
			elClk <= 1'b0;
			led1Clk <= 1'b0;
			led2Clk <= 1'b0;
		end else begin
			elClk <= latchWrite & regBus.regData[3];
			led1Clk <= latchWrite & regBus.regData[4];
			led2Clk <= latchWrite & regBus.regData[5];
		end
	end

	// Clock on top, data below
	assign elOut = {elClk, ledData[neoIoPkg::EL_W-1:0]};
	assign ledOut1 = {led1Clk, ledData};
	assign ledOut2 = {led2Clk, ledData};

endmodule

/* runSim.sh */
#!/bin/sh
# Build and run the neoIo testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module neoIoTb -f neoIo.f -o neoIoSim

# The simulator exits nonzero on a fatal error, the log decides the result
simStatus=0
./obj_dir/neoIoSim > sim.log 2>&1 || simStatus=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
	echo "Simulation FAILED (exit status $simStatus)"
	exit 1
fi
echo "Simulation finished without failure"

/* systemLatch.sv */
`timescale 1ns/1ps

module systemLatch (
	input logic CLK_68KCLK,
	input logic rst,
	ioRegIf.block regBus,
	input logic [neoIoPkg::ADDR_W-1:0] busAddr,
	output logic shadow,
	output logic palBank,
	output logic nSystem,
	output logic sramWriteLock,
	output logic cardWriteEnable,
	output logic cardRegEnable,
	output logic [1:0] vecAddrHi
);

	logic [7:0] latchBits;
	logic vecSwap;

	// Addressable latch: A3-A1 pick the bit, A4 is the value
	always_ff @(posedge CLK_68KCLK) begin
		if (rst)
			latchBits <= '0;
		else if (regBus.bitw1Strobe)
			latchBits[regBus.regAddr[3:1]] <= regBus.regAddr[4];
	end

	assign shadow = latchBits[neoIoPkg::LATCH_SHADOW];
	assign palBank = latchBits[neoIoPkg::LATCH_PALBNK];
	assign nSystem = latchBits[neoIoPkg::LATCH_NSYSTEM];
	assign sramWriteLock = latchBits[neoIoPkg::LATCH_SRAMWEN];
	// Card writes need both enables in agreement
	assign cardWriteEnable = ~latchBits[neoIoPkg::LATCH_NCARDWEN]
		& latchBits[neoIoPkg::LATCH_CARDWENB];
	// Active low latch bit
	assign cardRegEnable = ~latchBits[neoIoPkg::LATCH_NREGEN];

	// Vector table swap between 0x000000 and 0xC00000, first 128 bytes only
	// A23 and A22 must agree so the other two quarters pass untouched
	assign vecSwap = ~latchBits[neoIoPkg::LATCH_NVEC]
		& ~|busAddr[21:7]
		& (busAddr[23] == busAddr[22]);

	assign vecAddrHi = busAddr[23:22] ^ {2{vecSwap}};

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock (
	output logic clk
);

	// 4 ns period, so each phase is 2 ns
	initial clk = 1'b0;

	always #2 clk = ~clk;

endmodule
